/* include/mipsExec_params.svh */
`ifndef MIPS_EXEC_PARAMS_SVH
`define MIPS_EXEC_PARAMS_SVH

// width of register operands and results
`define DATA_WIDTH 32

// shift amount field and the low bits of rs used by variable shifts
`define SHAMT_WIDTH 5

// one quotient bit per divider iteration
`define DIV_STEPS (`DATA_WIDTH)

`endif

/* design/mipsIsaPkg.sv */
`include "mipsExec_params.svh"

package mipsIsaPkg;

    // register data and instruction words
    typedef logic [`DATA_WIDTH-1:0] word_t;
    typedef logic [31:0] instr_t;

    // instruction fields
    typedef logic [15:0] imm16_t;
    typedef logic [`SHAMT_WIDTH-1:0] shamt_t;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e
    } opcode_e;

    // function codes under SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL   = 6'h00,
        FN_SRL   = 6'h02,
        FN_SRA   = 6'h03,
        FN_SLLV  = 6'h04,
        FN_SRLV  = 6'h06,
        FN_SRAV  = 6'h07,
        FN_MFHI  = 6'h10,
        FN_MTHI  = 6'h11,
        FN_MFLO  = 6'h12,
        FN_MTLO  = 6'h13,
        FN_MULT  = 6'h18,
        FN_MULTU = 6'h19,
        FN_DIV   = 6'h1a,
        FN_DIVU  = 6'h1b,
        FN_ADDU  = 6'h21,
        FN_SUBU  = 6'h23,
        FN_AND   = 6'h24,
        FN_OR    = 6'h25,
        FN_XOR   = 6'h26,
        FN_SLT   = 6'h2a,
        FN_SLTU  = 6'h2b
    } funct_e;

endpackage

/* design/execPkg.sv */
`include "mipsExec_params.svh"

package execPkg;

    import mipsIsaPkg::*;

    // full product, or remainder and quotient side by side
    typedef logic [2*`DATA_WIDTH-1:0] dword_t;

    // one strobe per single-cycle ALU operation
    typedef struct packed {
        logic addu;
        logic addiu;
        logic subu;
        logic andR;
        logic andi;
        logic orR;
        logic ori;
        logic xorR;
        logic xori;
        logic sll;
        logic sllv;
        logic sra;
        logic srav;
        logic srl;
        logic srlv;
        logic slt;
        logic slti;
        logic sltu;
        logic sltiu;
    } aluOps_t;

    // operations that touch HI and LO
    typedef struct packed {
        logic mult;
        logic multu;
        logic div;
        logic divu;
        logic mfhi;
        logic mflo;
        logic mthi;
        logic mtlo;
    } hiLoOps_t;

    // decoder output
    typedef struct packed {
        aluOps_t alu;
        hiLoOps_t hiLo;
        word_t immediate;
        shamt_t shamt;
    } decoded_t;

    typedef struct packed {
        word_t data;
        logic writeEnable;
    } aluResult_t;

    typedef enum logic [1:0] {IDLE, RUN, FIX} divState_e;

endpackage

/* design/instrDecoder.sv */
`timescale 1ns/1ns
`include "mipsExec_params.svh"

module instrDecoder import mipsIsaPkg::*, execPkg::*; (
    input logic issue,
    input instr_t instruction,
    output decoded_t decoded
);

    opcode_e opcode;
    funct_e funct;
    imm16_t imm16;
    logic zeroExtend;
    word_t extImmediate;
    aluOps_t aluOps;
    hiLoOps_t hiLoOps;

    // field split
    assign opcode = opcode_e'(instruction[31:26]);
    assign funct = funct_e'(instruction[5:0]);
    assign imm16 = instruction[15:0];

    // logical immediates are zero-extended
    assign zeroExtend = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);

    // addiu, slti and sltiu sign-extend
    assign extImmediate = zeroExtend ?
        {{(`DATA_WIDTH-$bits(imm16_t)){1'b0}}, imm16} :
        {{(`DATA_WIDTH-$bits(imm16_t)){imm16[15]}}, imm16};

    // one strobe at most, and none without issue
    always_comb begin
        aluOps = '0;
        hiLoOps = '0;
        if (issue) begin
            case (opcode)
                OP_SPECIAL: begin
                    case (funct)
                        FN_SLL:   aluOps.sll = 1'b1;
                        FN_SRL:   aluOps.srl = 1'b1;
                        FN_SRA:   aluOps.sra = 1'b1;
                        FN_SLLV:  aluOps.sllv = 1'b1;
                        FN_SRLV:  aluOps.srlv = 1'b1;
                        FN_SRAV:  aluOps.srav = 1'b1;
                        FN_ADDU:  aluOps.addu = 1'b1;
                        FN_SUBU:  aluOps.subu = 1'b1;
                        FN_AND:   aluOps.andR = 1'b1;
                        FN_OR:    aluOps.orR = 1'b1;
                        FN_XOR:   aluOps.xorR = 1'b1;
                        FN_SLT:   aluOps.slt = 1'b1;
                        FN_SLTU:  aluOps.sltu = 1'b1;
                        // hi/lo group
                        FN_MFHI:  hiLoOps.mfhi = 1'b1;
                        FN_MFLO:  hiLoOps.mflo = 1'b1;
                        FN_MTHI:  hiLoOps.mthi = 1'b1;
                        FN_MTLO:  hiLoOps.mtlo = 1'b1;
                        FN_MULT:  hiLoOps.mult = 1'b1;
                        FN_MULTU: hiLoOps.multu = 1'b1;
                        FN_DIV:   hiLoOps.div = 1'b1;
                        FN_DIVU:  hiLoOps.divu = 1'b1;
                        // unknown funct leaves everything low
                        default:  aluOps = '0;
                    endcase
                end
                OP_ADDIU: aluOps.addiu = 1'b1;
                OP_SLTI:  aluOps.slti = 1'b1;
                OP_SLTIU: aluOps.sltiu = 1'b1;
                OP_ANDI:  aluOps.andi = 1'b1;
                OP_ORI:   aluOps.ori = 1'b1;
                OP_XORI:  aluOps.xori = 1'b1;
                default:  aluOps = '0;
            endcase
        end
    end

    // shamt sits in bits 10:6 of R-type words
    assign decoded = '{
        alu: aluOps,
        hiLo: hiLoOps,
        immediate: extImmediate,
        shamt: instruction[10:6]
    };

endmodule

/* design/alu.sv */
`timescale 1ns/1ns
`include "mipsExec_params.svh"

module alu import mipsIsaPkg::*, execPkg::*; (
    input aluOps_t ops,
    input word_t rsData,
    input word_t rtData,
    input word_t immediate,
    input shamt_t shamt,
    output aluResult_t result
);

    shamt_t varShamt;
    logic signedLess;
    logic signedLessImm;
    logic unsignedLess;
    logic unsignedLessImm;

    // variable shifts take only the low bits of rs
    assign varShamt = rsData[`SHAMT_WIDTH-1:0];

    // compares
    assign signedLess = $signed(rsData) < $signed(rtData);
    assign signedLessImm = $signed(rsData) < $signed(immediate);
    assign unsignedLess = rsData < rtData;
    // sltiu still uses the sign-extended immediate
    assign unsignedLessImm = rsData < immediate;

    always_comb begin
        // every known op writes a register
        result.writeEnable = |ops;
        if (ops.addu) begin
            result.data = rsData + rtData;
        end else if (ops.addiu) begin
            result.data = rsData + immediate;
        end else if (ops.subu) begin
            result.data = rsData - rtData;
        end else if (ops.andR) begin
            result.data = rsData & rtData;
        end else if (ops.andi) begin
            result.data = rsData & immediate;
        end else if (ops.orR) begin
            result.data = rsData | rtData;
        end else if (ops.ori) begin
            result.data = rsData | immediate;
        end else if (ops.xorR) begin
            result.data = rsData ^ rtData;
        end else if (ops.xori) begin
            result.data = rsData ^ immediate;
        end else if (ops.sll) begin
            result.data = rtData << shamt;
        end else if (ops.sllv) begin
            result.data = rtData << varShamt;
        end else if (ops.sra) begin
            result.data = $signed(rtData) >>> shamt;
        end else if (ops.srav) begin
            result.data = $signed(rtData) >>> varShamt;
        end else if (ops.srl) begin
            result.data = rtData >> shamt;
        end else if (ops.srlv) begin
            result.data = rtData >> varShamt;
        end else if (ops.slt) begin
            result.data = word_t'(signedLess);
        end else if (ops.slti) begin
            result.data = word_t'(signedLessImm);
        end else if (ops.sltu) begin
            result.data = word_t'(unsignedLess);
        end else if (ops.sltiu) begin
            result.data = word_t'(unsignedLessImm);
        end else begin
            // idle
            result.data = '0;
        end
    end

endmodule

/* design/mulDivUnit.sv */
`timescale 1ns/1ns
`include "mipsExec_params.svh"

module mulDivUnit import mipsIsaPkg::*, execPkg::*; (
    input logic clk,
    input logic reset,
    input hiLoOps_t ops,
    input word_t rsData,
    input word_t rtData,
    output word_t hi,
    output word_t lo,
    output logic busy
);

    localparam int countWidth = $clog2(`DIV_STEPS);

    divState_e state;
    logic [countWidth-1:0] stepCount;
    logic startDiv;
    dword_t product;

    // divider datapath
    logic dividendNeg;
    logic divisorNeg;
    word_t dividendMag;
    word_t divisorMagNext;
    word_t divisorMag;
    logic negQuot;
    logic negRem;
    dword_t acc;
    logic [`DATA_WIDTH:0] trial;
    dword_t stepAcc;
    word_t quotMag;
    word_t remMag;
    word_t quotient;
    word_t remainder;

    // signed or unsigned 64-bit product
    always_comb begin
        if (ops.mult) begin
            product = $signed(rsData) * $signed(rtData);
        end else begin
            product = rsData * rtData;
        end
    end

    // only start from idle
    assign startDiv = (state == IDLE) && (ops.div || ops.divu);

    // operand magnitudes, signs only matter for div
    assign dividendNeg = ops.div && rsData[`DATA_WIDTH-1];
    assign divisorNeg = ops.div && rtData[`DATA_WIDTH-1];
    assign dividendMag = dividendNeg ? -rsData : rsData;
    assign divisorMagNext = divisorNeg ? -rtData : rtData;

    // restoring step on the shifted partial remainder
    // one extra bit so divisors above 2^31 still compare right
    assign trial = acc[2*`DATA_WIDTH-1:`DATA_WIDTH-1] - {1'b0, divisorMag};
    assign stepAcc = trial[`DATA_WIDTH] ?
        {acc[2*`DATA_WIDTH-2:0], 1'b0} :
        {trial[`DATA_WIDTH-1:0], acc[`DATA_WIDTH-2:0], 1'b1};

    // remainder high, quotient low
    assign quotMag = acc[`DATA_WIDTH-1:0];
    assign remMag = acc[2*`DATA_WIDTH-1:`DATA_WIDTH];

    // quotient sign from both operands, remainder follows dividend
    assign quotient = negQuot ? -quotMag : quotMag;
    assign remainder = negRem ? -remMag : remMag;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            stepCount <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (startDiv) begin
                        state <= RUN;
                        stepCount <= '0;
                    end
                end
                RUN: begin
                    stepCount <= stepCount + 1'b1;
                    if (stepCount == countWidth'(`DIV_STEPS - 1)) begin
                        state <= FIX;
                    end
                end
                // sign fix cycle, results land on hi/lo here
                FIX: state <= IDLE;
                default: state <= IDLE;
            endcase

            if (ops.mult || ops.multu) begin
                {hi, lo} <= product;
            end else if (ops.mthi) begin
                hi <= rsData;
            end else if (ops.mtlo) begin
                lo <= rsData;
            end else if (state == FIX) begin
                hi <= remainder;
                lo <= quotient;
            end
        end
    end

    // working registers of the divider
    always_ff @(posedge clk) begin
        if (startDiv) begin
            acc <= {{`DATA_WIDTH{1'b0}}, dividendMag};
            divisorMag <= divisorMagNext;
            negQuot <= dividendNeg ^ divisorNeg;
            negRem <= dividendNeg;
        end else if (state == RUN) begin
            acc <= stepAcc;
        end
    end

    assign busy = (state != IDLE);

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ns

module executeStage import mipsIsaPkg::*, execPkg::*; (
    input logic clk,
    input logic reset,
    input logic issue,
    input instr_t instruction,
    input word_t rsData,
    input word_t rtData,
    output word_t data,
    output logic regWriteEnable,
    output logic resultValid,
    output word_t hi,
    output word_t lo,
    output logic busy
);

    logic accepted;
    logic producesResult;
    decoded_t decoded;
    aluResult_t aluResult;
    aluResult_t nextResult;
    aluResult_t resultReg;
    logic validReg;

    // issues during a divide are dropped
    assign accepted = issue && !busy;

    instrDecoder u_decoder (
        .issue(accepted),
        .instruction(instruction),
        .decoded(decoded)
    );

    alu u_alu (
        .ops(decoded.alu),
        .rsData(rsData),
        .rtData(rtData),
        .immediate(decoded.immediate),
        .shamt(decoded.shamt),
        .result(aluResult)
    );

    mulDivUnit u_mulDiv (
        .clk(clk),
        .reset(reset),
        .ops(decoded.hiLo),
        .rsData(rsData),
        .rtData(rtData),
        .hi(hi),
        .lo(lo),
        .busy(busy)
    );

    // mfhi/mflo replace the alu data before the result register
    always_comb begin
        nextResult = aluResult;
        if (decoded.hiLo.mfhi) begin
            nextResult.data = hi;
            nextResult.writeEnable = 1'b1;
        end else if (decoded.hiLo.mflo) begin
            nextResult.data = lo;
            nextResult.writeEnable = 1'b1;
        end
    end

    // mult, mt* and div produce no register result
    assign producesResult = |decoded.alu || decoded.hiLo.mfhi || decoded.hiLo.mflo;

    always_ff @(posedge clk) begin
        if (reset) begin
            resultReg <= '0;
            validReg <= 1'b0;
        end else begin
            validReg <= accepted && producesResult;
            resultReg.writeEnable <= nextResult.writeEnable;
            // data holds until the next result
            if (nextResult.writeEnable) begin
                resultReg.data <= nextResult.data;
            end
        end
    end

    assign data = resultReg.data;
    assign regWriteEnable = resultReg.writeEnable;
    assign resultValid = validReg;

endmodule

/* tests/executeStageTb.sv */
`timescale 1ns/1ns
`include "mipsExec_params.svh"

module executeStageTb
    import mipsIsaPkg::*, execPkg::*;
();

    localparam int numRandom = 8;
    // alu issues: 13 r-type x 3 shamts, 6 immediate ops x 5 immediates
    localparam int aluIssues = (13 * 3 + 6 * 5) * (25 + numRandom);
    localparam int divIssues = 2 * (8 + numRandom) + 1;
    localparam longint watchdogNs = (aluIssues * 2 + divIssues * (`DIV_STEPS + 4) + 2000) * 20;

    logic clk;
    logic reset;
    logic issue;
    instr_t instruction;
    word_t rsData;
    word_t rtData;
    word_t data;
    logic regWriteEnable;
    logic resultValid;
    word_t hi;
    word_t lo;
    logic busy;
    int unsigned seedDummy;

    executeStage u_dut (
        .clk(clk),
        .reset(reset),
        .issue(issue),
        .instruction(instruction),
        .rsData(rsData),
        .rtData(rtData),
        .data(data),
        .regWriteEnable(regWriteEnable),
        .resultValid(resultValid),
        .hi(hi),
        .lo(lo),
        .busy(busy)
    );

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // register fields are don't-care here
    function automatic instr_t rType(funct_e fn, shamt_t sh);
        return {OP_SPECIAL, 5'd8, 5'd9, 5'd10, sh, fn};
    endfunction

    function automatic instr_t iType(opcode_e op, imm16_t imm);
        return {op, 5'd8, 5'd9, imm};
    endfunction

    // reference for single-cycle ops, from the MIPS definitions
    function automatic word_t aluRef(instr_t instr, word_t rs, word_t rt);
        word_t sImm;
        word_t zImm;
        shamt_t sh;
        shamt_t vsh;
        word_t res;
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0000, instr[15:0]};
        sh = instr[10:6];
        vsh = rs[4:0];
        res = '0;
        case (instr[31:26])
            OP_SPECIAL: begin
                case (instr[5:0])
                    FN_ADDU: res = rs + rt;
                    FN_SUBU: res = rs - rt;
                    FN_AND:  res = rs & rt;
                    FN_OR:   res = rs | rt;
                    FN_XOR:  res = rs ^ rt;
                    FN_SLL:  res = rt << sh;
                    FN_SLLV: res = rt << vsh;
                    FN_SRL:  res = rt >> sh;
                    FN_SRLV: res = rt >> vsh;
                    FN_SRA:  res = $signed(rt) >>> sh;
                    FN_SRAV: res = $signed(rt) >>> vsh;
                    FN_SLT:  res = {31'b0, $signed(rs) < $signed(rt)};
                    FN_SLTU: res = {31'b0, rs < rt};
                    default: res = '0;
                endcase
            end
            OP_ADDIU: res = rs + sImm;
            OP_ANDI:  res = rs & zImm;
            OP_ORI:   res = rs | zImm;
            OP_XORI:  res = rs ^ zImm;
            OP_SLTI:  res = {31'b0, $signed(rs) < $signed(sImm)};
            // unsigned compare, immediate still sign-extended
            OP_SLTIU: res = {31'b0, rs < sImm};
            default:  res = '0;
        endcase
        return res;
    endfunction

    // low 64 bits of the extended product cover both signednesses
    function automatic logic [63:0] mulRef(word_t a, word_t b, logic isSigned);
        logic [63:0] ea;
        logic [63:0] eb;
        ea = isSigned ? {{32{a[31]}}, a} : {32'h0, a};
        eb = isSigned ? {{32{b[31]}}, b} : {32'h0, b};
        return ea * eb;
    endfunction

    // {remainder, quotient}; zero divisor gives all-ones magnitude, remainder = dividend
    function automatic logic [63:0] divRef(word_t a, word_t b, logic isSigned);
        word_t quot;
        word_t rem;
        if (b == '0) begin
            quot = '1;
            if (isSigned && a[31]) begin
                quot = -quot;
            end
            rem = a;
        end else if (isSigned) begin
            quot = $signed(a) / $signed(b);
            rem = $signed(a) % $signed(b);
        end else begin
            quot = a / b;
            rem = a % b;
        end
        return {rem, quot};
    endfunction

    task automatic checkValue(string name, logic [63:0] actual, logic [63:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "check mismatch");
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic issueInstr(instr_t instr, word_t rs, word_t rt);
        instruction = instr;
        rsData = rs;
        rtData = rt;
        issue = 1'b1;
        @(posedge clk);
        #2;
        issue = 1'b0;
    endtask

    // counts cycles until busy drops
    task automatic waitIdle(output int cycles);
        cycles = 0;
        while (busy) begin
            if (cycles > `DIV_STEPS + 8) begin
                $display("divider never left the busy state");
                $display("sim failed");
                $fatal(1, "divider hang");
            end
            cycles++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic aluCase(instr_t instr, word_t rs, word_t rt);
        issueInstr(instr, rs, rt);
        checkValue("resultValid", resultValid, 1);
        checkValue("regWriteEnable", regWriteEnable, 1);
        checkValue($sformatf("data (instr 0x%h)", instr), data, aluRef(instr, rs, rt));
    endtask

    task automatic testReset();
        checkValue("resultValid", resultValid, 0);
        checkValue("regWriteEnable", regWriteEnable, 0);
        checkValue("busy", busy, 0);
        checkValue("hi", hi, 0);
        checkValue("lo", lo, 0);
        checkValue("data", data, 0);
    endtask

    task automatic testAluOps();
        funct_e rFuncts[13];
        opcode_e iOps[6];
        word_t edgeVals[5];
        imm16_t immVals[4];
        shamt_t sh;
        imm16_t imm;
        rFuncts = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SLLV,
                    FN_SRL, FN_SRLV, FN_SRA, FN_SRAV, FN_SLT, FN_SLTU};
        iOps = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
        // low five bits give variable shifts of 0, 1 and 31
        edgeVals = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        immVals = '{16'h0000, 16'h0001, 16'h8000, 16'hffff};
        foreach (rFuncts[f]) begin
            for (int k = 0; k < 3; k++) begin
                if (k == 0) sh = '0;
                else if (k == 1) sh = '1;
                else sh = shamt_t'($urandom);
                foreach (edgeVals[i]) begin
                    foreach (edgeVals[j]) begin
                        aluCase(rType(rFuncts[f], sh), edgeVals[i], edgeVals[j]);
                    end
                end
                for (int r = 0; r < numRandom; r++) begin
                    aluCase(rType(rFuncts[f], sh), $urandom, $urandom);
                end
            end
        end
        foreach (iOps[o]) begin
            for (int k = 0; k < 5; k++) begin
                // last pass uses a random immediate
                imm = (k < 4) ? immVals[k] : imm16_t'($urandom);
                foreach (edgeVals[i]) begin
                    foreach (edgeVals[j]) begin
                        aluCase(iType(iOps[o], imm), edgeVals[i], edgeVals[j]);
                    end
                end
                for (int r = 0; r < numRandom; r++) begin
                    aluCase(iType(iOps[o], imm), $urandom, $urandom);
                end
            end
        end
    endtask

    task automatic multCase(funct_e fn, word_t a, word_t b);
        issueInstr(rType(fn, '0), a, b);
        checkValue("resultValid", resultValid, 0);
        checkValue("regWriteEnable", regWriteEnable, 0);
        checkValue("{hi,lo}", {hi, lo}, mulRef(a, b, fn == FN_MULT));
    endtask

    task automatic testMult();
        funct_e fns[2];
        fns = '{FN_MULT, FN_MULTU};
        foreach (fns[f]) begin
            multCase(fns[f], 32'hffff_ffff, 32'hffff_ffff);
            multCase(fns[f], 32'h8000_0000, 32'h7fff_ffff);
            multCase(fns[f], 32'hffff_fff9, 32'd100);
            for (int r = 0; r < numRandom; r++) begin
                multCase(fns[f], $urandom, $urandom);
                // force negative operands
                multCase(fns[f], $urandom | 32'h8000_0000, $urandom | 32'h8000_0000);
            end
        end
    endtask

    task automatic divCase(funct_e fn, word_t a, word_t b);
        int cycles;
        logic [63:0] expected;
        expected = divRef(a, b, fn == FN_DIV);
        issueInstr(rType(fn, '0), a, b);
        checkValue("busy", busy, 1);
        checkValue("resultValid", resultValid, 0);
        waitIdle(cycles);
        checkValue("busy cycles", cycles, `DIV_STEPS + 1);
        checkValue("hi", hi, expected[63:32]);
        checkValue("lo", lo, expected[31:0]);
    endtask

    task automatic testDiv();
        funct_e fns[2];
        word_t dividends[8];
        word_t divisors[8];
        fns = '{FN_DIV, FN_DIVU};
        // 100 and 7 in all sign combinations, then edges and zero divisors
        dividends = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c,
                      32'h7fff_ffff, 32'h8000_0000, 32'd12345, 32'hffff_ff9c};
        divisors = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9,
                     32'd1, 32'd3, 32'd0, 32'd0};
        foreach (fns[f]) begin
            foreach (dividends[i]) begin
                divCase(fns[f], dividends[i], divisors[i]);
            end
            for (int r = 0; r < numRandom; r++) begin
                divCase(fns[f], $urandom, $urandom >> (r * 4));
            end
        end
    endtask

    task automatic testMoves();
        word_t a;
        word_t b;
        a = $urandom;
        b = $urandom;
        issueInstr(rType(FN_MTHI, '0), a, '0);
        checkValue("resultValid", resultValid, 0);
        checkValue("hi", hi, a);
        issueInstr(rType(FN_MTLO, '0), b, '0);
        checkValue("lo", lo, b);
        checkValue("hi", hi, a);
        issueInstr(rType(FN_MFHI, '0), '0, '0);
        checkValue("resultValid", resultValid, 1);
        checkValue("regWriteEnable", regWriteEnable, 1);
        checkValue("data", data, a);
        issueInstr(rType(FN_MFLO, '0), '0, '0);
        checkValue("resultValid", resultValid, 1);
        checkValue("regWriteEnable", regWriteEnable, 1);
        checkValue("data", data, b);
    endtask

    // issues during a divide must not disturb it
    task automatic testIssueDuringDivide();
        word_t a;
        word_t b;
        logic [63:0] expected;
        a = $urandom;
        b = ($urandom >> 8) | 32'h1;
        expected = divRef(a, b, 1'b0);
        issueInstr(rType(FN_DIVU, '0), a, b);
        issueInstr(rType(FN_ADDU, '0), 32'd5, 32'd6);
        checkValue("resultValid", resultValid, 0);
        issueInstr(rType(FN_MTHI, '0), $urandom, '0);
        // mult in every busy cycle, sign-fix cycle included
        while (busy) begin
            issueInstr(rType(FN_MULT, '0), $urandom, $urandom);
        end
        checkValue("hi", hi, expected[63:32]);
        checkValue("lo", lo, expected[31:0]);
    endtask

    task automatic testUnknown();
        issueInstr({6'h3f, 26'h0123456}, $urandom, $urandom);
        checkValue("resultValid", resultValid, 0);
        checkValue("regWriteEnable", regWriteEnable, 0);
        // funct 0x01 is not defined under SPECIAL
        issueInstr({OP_SPECIAL, 20'h12345, 6'h01}, $urandom, $urandom);
        checkValue("resultValid", resultValid, 0);
        checkValue("regWriteEnable", regWriteEnable, 0);
    endtask

    // watchdog sized from the test lengths
    initial begin
        #(watchdogNs);
        $display("timeout: tests did not finish within %0d ns", watchdogNs);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seedDummy = $urandom(32'h4ae73fb2);
        reset = 1'b1;
        issue = 1'b0;
        instruction = '0;
        rsData = '0;
        rtData = '0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        testReset();
        testAluOps();
        testMult();
        testDiv();
        testMoves();
        testIssueDuringDivide();
        testUnknown();
        $display("sim passed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+include
design/mipsIsaPkg.sv
design/execPkg.sv
design/instrDecoder.sv
design/alu.sv
design/mulDivUnit.sv
design/executeStage.sv
tests/executeStageTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = executeStageTb
FILELIST = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# awk echoes the run and sets the exit status from the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } /^sim passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
